//--- design/boxcar_avg.sv
////////////////////////////////////////////////////////////
// per-channel moving average over LENGTH beats, LENGTH = 2^n
// channels arrive interleaved, avg is registered one enable late
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module boxcar_avg
  import peak_stream_pkg::*;
  import peak_ctrl_pkg::*;
#(
  parameter int LENGTH = 16
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 en,
  input  chan_idx_t                 chan,
  input  wire logic [MAG_WIDTH-1:0] mag,
  output logic [MAG_WIDTH-1:0]      avg
);

  localparam int SHIFT = cnt_width(LENGTH);
  localparam int SUM_W = MAG_WIDTH + SHIFT;

  // running sums, one per channel
  logic [SUM_W-1:0] sum_q [NUM_CHANNELS];
  logic [SUM_W-1:0] sum_next;
  // history words in and out
  chan_word_u       mag_w;
  chan_word_u       old_w;

  always_comb begin
    mag_w        = '0;
    mag_w.mw.mag = mag;
  end

  // interleaved history, LENGTH beats of every channel
  delay_line #(
    .DEPTH (LENGTH * NUM_CHANNELS)
  ) u_hist (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .din   (mag_w),
    .dout  (old_w)
  );

  // old sample already sits in the sum, so no underflow
  assign sum_next = sum_q[chan] + SUM_W'(mag) - SUM_W'(old_w.mw.mag);

  ////////////////////////////////////////////////////////////
  // sum update and scaled output
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        sum_q[i] <= '0;
      end
      avg <= '0;
    end else if (en) begin
      sum_q[chan] <= sum_next;
      // divide by LENGTH
      avg <= MAG_WIDTH'(sum_next >> SHIFT);
    end
  end

endmodule

`default_nettype wire

//--- design/cabs_approx.sv
////////////////////////////////////////////////////////////
// |z| ~ max(|re|,|im|) + min(|re|,|im|)/2, two enabled stages
// result trails din by CABS_LATENCY enabled cycles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cabs_approx
  import peak_stream_pkg::*;
  import peak_ctrl_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 en,
  input  chan_word_u                din,
  output logic [MAG_WIDTH-1:0]      mag
);

  // stage one registers
  logic [SAMPLE_WIDTH-1:0] abs_re;
  logic [SAMPLE_WIDTH-1:0] abs_im;
  // sorted halves feeding stage two
  logic [SAMPLE_WIDTH-1:0] big;
  logic [SAMPLE_WIDTH-1:0] lesser;

  ////////////////////////////////////////////////////////////
  // stage one, absolute values
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      abs_re <= '0;
      abs_im <= '0;
    end else if (en) begin
      // -32768 maps to 0x8000, still correct as unsigned
      abs_re <= (din.iq.re < 0) ? unsigned'(-din.iq.re) : unsigned'(din.iq.re);
      abs_im <= (din.iq.im < 0) ? unsigned'(-din.iq.im) : unsigned'(din.iq.im);
    end
  end

  always_comb begin
    big    = (abs_re >= abs_im) ? abs_re : abs_im;
    lesser = (abs_re >= abs_im) ? abs_im : abs_re;
  end

  ////////////////////////////////////////////////////////////
  // stage two, alpha max plus beta min
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mag <= '0;
    end else if (en) begin
      mag <= MAG_WIDTH'(big) + MAG_WIDTH'(lesser >> 1);
    end
  end

endmodule

`default_nettype wire

//--- design/delay_line.sv
////////////////////////////////////////////////////////////
// enabled shift register for one channel word
// DEPTH must be at least 1, taps clear to zero on reset
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module delay_line
  import peak_stream_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       en,
  input  chan_word_u      din,
  output chan_word_u      dout
);

  // taps[0] newest, taps[DEPTH-1] oldest
  chan_word_u taps [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else if (en) begin
      taps[0] <= din;
      // advance the chain one step
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // word from DEPTH enabled cycles ago
  assign dout = taps[DEPTH-1];

endmodule

`default_nettype wire

//--- design/peak_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// control types of the detector
// count helpers expect a power-of-two burst length
////////////////////////////////////////////////////////////
`default_nettype none

package peak_ctrl_pkg;

  // channel index, sized for 4 channels
  typedef logic [1:0] chan_idx_t;

  localparam int MAG_WIDTH    = 17;
  localparam int CABS_LATENCY = 2;

  // fill doubles as the holdoff after reset and after each burst
  typedef enum logic [1:0] {fill, idle, burst} detect_state_t;

  // counter width for a burst of len beats
  function automatic int cnt_width(input int len);
    return $clog2(len);
  endfunction

  // beats on each side of the peak
  function automatic int burst_half(input int len);
    return len / 2;
  endfunction

endpackage

`default_nettype wire

//--- design/peak_detect_top.sv
////////////////////////////////////////////////////////////
// top level, burst of 16 beats, threshold (avg + 1) * 4
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module peak_detect_top
  import peak_stream_pkg::*;
#(
  parameter int BURST_LENGTH = 16,
  parameter int THRESH_SHIFT = 2
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    s_valid,
  output logic         s_ready,
  input  stream_beat_t s_beat,
  output logic         m_valid,
  input  wire logic    m_ready,
  output stream_beat_t m_beat
);

  // detector core
  peak_detector #(
    .BURST_LENGTH (BURST_LENGTH),
    .THRESH_SHIFT (THRESH_SHIFT)
  ) u_det (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

endmodule

`default_nettype wire

//--- design/peak_detector.sv
////////////////////////////////////////////////////////////
// one channel per cycle, a beat accepted every NUM_CHANNELS cycles
// pipeline only advances with s_valid, input stalls while a burst drains
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module peak_detector
  import peak_stream_pkg::*;
  import peak_ctrl_pkg::*;
#(
  parameter int BURST_LENGTH = 16,
  parameter int THRESH_SHIFT = 2
) (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   s_valid,
  output logic        s_ready,
  input  stream_beat_t s_beat,
  output logic        m_valid,
  input  wire logic   m_ready,
  output stream_beat_t m_beat
);

  localparam int HALF = burst_half(BURST_LENGTH);
  localparam int CW = cnt_width(BURST_LENGTH);
  // avg window ends at beat k+HALF-1, one extra for the avg register
  localparam int TAP_DEPTH = NUM_CHANNELS * (HALF - 1) + 1;
  localparam int TW = MAG_WIDTH + THRESH_SHIFT + 1;
  localparam chan_idx_t LAST_CHAN = chan_idx_t'(NUM_CHANNELS - 1);

  // sequencing
  chan_idx_t chan_idx;
  logic      en;
  logic      s_take;
  logic      m_take;
  // magnitude path
  chan_word_u           cabs_din;
  logic [MAG_WIDTH-1:0] mag;
  chan_idx_t            mag_chan;
  chan_idx_t            cmp_chan;
  logic                 cmp_last;
  chan_word_u           mag_w;
  chan_word_u           tap_w;
  logic [MAG_WIDTH-1:0] avg;
  logic [TW-1:0]        thresh;
  logic                 over;
  logic                 peak_acc;
  logic                 peak_hit;
  logic                 start_burst;
  // framing
  detect_state_t state;
  logic [CW-1:0] cnt;
  chan_word_u [NUM_CHANNELS-1:0] mem_in;
  chan_word_u [NUM_CHANNELS-1:0] beat_mem [BURST_LENGTH];

  ////////////////////////////////////////////////////////////
  // channel sequencing and handshakes
  ////////////////////////////////////////////////////////////
  // ready on the last channel, never with a pending peak in idle
  assign s_ready = (chan_idx == LAST_CHAN) &&
                   ((state == fill) || ((state == idle) && !peak_hit));
  assign s_take  = s_valid && s_ready;
  assign m_valid = (state == burst);
  assign m_take  = m_valid && m_ready;
  // hold at the last channel until the beat is taken
  assign en = s_valid && ((chan_idx != LAST_CHAN) || s_ready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chan_idx <= '0;
    end else if (en) begin
      chan_idx <= (chan_idx == LAST_CHAN) ? '0 : chan_idx + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // magnitude, average and centered tap
  ////////////////////////////////////////////////////////////
  assign cabs_din = s_beat.chan[chan_idx];

  cabs_approx u_cabs (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .din   (cabs_din),
    .mag   (mag)
  );

  // channel at the cabs output, then one later at the compare
  assign mag_chan = chan_idx - chan_idx_t'(CABS_LATENCY);
  assign cmp_chan = chan_idx - chan_idx_t'(CABS_LATENCY + 1);
  assign cmp_last = (cmp_chan == LAST_CHAN);

  boxcar_avg #(
    .LENGTH (BURST_LENGTH)
  ) u_avg (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .chan  (mag_chan),
    .mag   (mag),
    .avg   (avg)
  );

  always_comb begin
    mag_w        = '0;
    mag_w.mw.mag = mag;
  end

  // magnitude of the beat in the middle of the avg window
  delay_line #(
    .DEPTH (TAP_DEPTH)
  ) u_tap (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .din   (mag_w),
    .dout  (tap_w)
  );

  // (avg + 1) << THRESH_SHIFT, wide enough not to wrap
  assign thresh = (TW'(avg) + TW'(1)) << THRESH_SHIFT;
  assign over   = TW'(tap_w.mw.mag) > thresh;
  assign start_burst = (state == idle) && peak_hit;

  // or over the channels, peak_hit valid until the next enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peak_acc <= 1'b0;
      peak_hit <= 1'b0;
    end else if (en) begin
      peak_acc <= cmp_last ? 1'b0 : (peak_acc | over);
      peak_hit <= cmp_last & (peak_acc | over);
    end else if (start_burst) begin
      peak_hit <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // state and burst counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fill;
      cnt   <= '0;
    end else begin
      case (state)
        // skip decisions for beats already sent or before reset
        fill: begin
          if (s_take) begin
            if (cnt == CW'(HALF - 1)) begin
              state <= idle;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        idle: begin
          if (peak_hit) begin
            state <= burst;
          end
        end
        burst: begin
          if (m_take) begin
            if (cnt == CW'(BURST_LENGTH - 1)) begin
              state <= fill;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= fill;
          cnt   <= '0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // beat memory, oldest at index 0
  ////////////////////////////////////////////////////////////
  // output rotates, so the window is intact after a burst
  assign mem_in = s_take ? s_beat.chan : beat_mem[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < BURST_LENGTH; i++) begin
        beat_mem[i] <= '0;
      end
    end else if (s_take || m_take) begin
      for (int i = 0; i < BURST_LENGTH - 1; i++) begin
        beat_mem[i] <= beat_mem[i+1];
      end
      beat_mem[BURST_LENGTH-1] <= mem_in;
    end
  end

  always_comb begin
    m_beat.chan = beat_mem[0];
    m_beat.last = (state == burst) && (cnt == CW'(BURST_LENGTH - 1));
  end

endmodule

`default_nettype wire

//--- design/peak_stream_pkg.sv
////////////////////////////////////////////////////////////
// stream types for the peak detector, 4 channels of 16-bit iq
// channel words are 32 bits, beats carry a last flag on output only
////////////////////////////////////////////////////////////
`default_nettype none

package peak_stream_pkg;

  localparam int NUM_CHANNELS = 4;
  localparam int SAMPLE_WIDTH = 16;

  // one complex sample, re in the upper half
  typedef struct packed {
    logic signed [SAMPLE_WIDTH-1:0] re;
    logic signed [SAMPLE_WIDTH-1:0] im;
  } iq_sample_t;

  // magnitude view of a channel word, zero padded
  typedef struct packed {
    logic [SAMPLE_WIDTH-2:0] pad;
    logic [SAMPLE_WIDTH:0]   mag;
  } mag_word_t;

  // same 32 bits read as iq on input, as magnitude inside
  typedef union packed {
    iq_sample_t iq;
    mag_word_t  mw;
  } chan_word_u;

  typedef struct packed {
    chan_word_u [NUM_CHANNELS-1:0] chan;
    logic                          last;
  } stream_beat_t;

endpackage

`default_nettype wire

//--- sim/peak_detect_assertions.sv
////////////////////////////////////////////////////////////
// handshake and framing properties, bound into peak_detector
// burst length must be a power of two for the beat counter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module peak_detect_assertions
  import peak_stream_pkg::*;
#(
  parameter int BURST_LENGTH = 16
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    s_ready,
  input  wire logic    m_valid,
  input  wire logic    m_ready,
  input  stream_beat_t m_beat
);

  // output beats taken so far, wraps once per burst
  logic [$clog2(BURST_LENGTH)-1:0] out_cnt;
  // read by the testbench top at the end of the run
  int fail_count = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt <= '0;
    end else if (m_valid && m_ready) begin
      out_cnt <= out_cnt + 1'b1;
    end
  end

  // stalled beat stays put
  hold_beat: assert property (@(posedge clk) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else begin
      fail_count++;
      $error("output beat changed while the sink stalled");
    end

  // input and output never open together, nor on the edge a burst starts
  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    s_ready |-> (!m_valid ##1 !m_valid))
    else begin
      fail_count++;
      $error("s_ready high with a burst under way or starting");
    end

  // last exactly on the final beat of each burst
  last_place: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> (m_beat.last == (out_cnt == BURST_LENGTH - 1)))
    else begin
      fail_count++;
      $error("last flag out of place, beat %0d of the burst", out_cnt);
    end

endmodule

`default_nettype wire

//--- sim/peak_detect_checker.sv
////////////////////////////////////////////////////////////
// rebuilds each burst from accepted input beats, counts errors
// peak index is global, counted from the first accepted beat
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module peak_detect_checker
  import peak_stream_pkg::*;
#(
  parameter int BURST_LENGTH = 16
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    s_valid,
  input  wire logic    s_ready,
  input  stream_beat_t s_beat,
  input  wire logic    m_valid,
  input  wire logic    m_ready,
  input  stream_beat_t m_beat
);

  typedef chan_word_u [NUM_CHANNELS-1:0] beat_words_t;

  // every accepted input beat, in order
  beat_words_t hist [$];
  // -1 when the running test expects no burst
  int exp_peak  = -1;
  int test_num  = 0;
  int out_pos   = 0;
  int bursts    = 0;
  int test_errs = 0;
  int errors    = 0;
  int bad_tests = 0;

  ////////////////////////////////////////////////////////////
  // per beat compare
  ////////////////////////////////////////////////////////////
  task automatic check_output();
    beat_words_t want;
    int          idx;
    logic        want_last;
    if (out_pos == 0) begin
      bursts++;
    end
    if (exp_peak < 0 || bursts > 1) begin
      if (out_pos == 0) begin
        $display("test %0d: a burst appeared where none was expected", test_num);
        test_errs++;
      end
    end else begin
      // window runs from peak - half to peak + half - 1
      idx = exp_peak - BURST_LENGTH / 2 + out_pos;
      // beats before the stream started are zero
      want = (idx < 0 || idx >= hist.size()) ? '0 : hist[idx];
      want_last = (out_pos == BURST_LENGTH - 1);
      if (m_beat.chan !== want) begin
        $display("mismatch m_beat beat %0d of test %0d: got %h expected %h",
                 out_pos, test_num, m_beat.chan, want);
        test_errs++;
      end
      if (m_beat.last !== want_last) begin
        $display("mismatch last beat %0d of test %0d: got %h expected %h",
                 out_pos, test_num, m_beat.last, want_last);
        test_errs++;
      end
    end
    out_pos = (out_pos + 1) % BURST_LENGTH;
  endtask

  // inputs are driven on the falling edge, stable here
  always @(posedge clk) begin
    if (rst_n) begin
      if (s_valid && s_ready) begin
        hist.push_back(s_beat.chan);
      end
      if (m_valid && m_ready) begin
        check_output();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test bookkeeping
  ////////////////////////////////////////////////////////////
  task automatic begin_test(input int peak);
    test_num++;
    exp_peak  = peak;
    bursts    = 0;
    test_errs = 0;
  endtask

  task automatic close_test();
    if (exp_peak >= 0 && bursts == 0) begin
      $display("test %0d: the expected burst never came out", test_num);
      test_errs++;
    end
    if (out_pos != 0) begin
      $display("test %0d: burst cut short after %0d beats", test_num, out_pos);
      test_errs++;
    end
    $display("test %0d finished with %0d errors", test_num, test_errs);
    errors += test_errs;
    if (test_errs != 0) begin
      bad_tests++;
    end
  endtask

  task automatic report_counts(input int beats_sent);
    // every driven beat must show up as accepted
    if (hist.size() != beats_sent) begin
      $display("input beats lost, %0d driven but %0d accepted", beats_sent, hist.size());
      errors++;
    end
    $display("tests run %0d, tests with errors %0d, errors %0d",
             test_num, bad_tests, errors);
  endtask

endmodule

`default_nettype wire

//--- sim/peak_detect_tb.sv
////////////////////////////////////////////////////////////
// runs the beat sequences of sim/peak_tests.txt through the top
// one continuous stream, the DUT is reset only once at the start
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module peak_detect_tb
  import peak_stream_pkg::*;
();

  localparam int BURST_LENGTH  = 16;
  localparam int THRESH_SHIFT  = 2;
  localparam int MEM_WORDS     = 256;
  localparam int BEAT_TIMEOUT  = 400;
  localparam int IDLE_TIMEOUT  = 400;
  localparam int RESET_TIMEOUT = 50;

  logic         clk;
  logic         rst_n;
  logic         s_valid;
  logic         s_ready;
  stream_beat_t s_beat;
  logic         m_valid;
  logic         m_ready;
  stream_beat_t m_beat;

  // test file image, headers and segments back to back
  logic [31:0] tests_mem [MEM_WORDS];
  logic        bp_mode;
  logic [31:0] rnd;
  integer      seed;
  int          sent;
  int          n_tests;
  int          ptr;
  int          n_seg;
  int          peak;
  int          rep;
  stream_beat_t beat;

  tb_clock u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  peak_detect_top #(
    .BURST_LENGTH (BURST_LENGTH),
    .THRESH_SHIFT (THRESH_SHIFT)
  ) dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

  peak_detect_checker #(
    .BURST_LENGTH (BURST_LENGTH)
  ) chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

  bind peak_detector peak_detect_assertions #(
    .BURST_LENGTH (BURST_LENGTH)
  ) u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_ready (s_ready),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

  // sink stall pattern, random only in back-pressure tests
  always @(negedge clk) begin
    if (bp_mode) begin
      rnd     = $random(seed);
      m_ready = rnd[0];
    end else begin
      m_ready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  task automatic fail_run(input string why);
    $display("error: %s", why);
    $display("test failed");
    $finish;
  endtask

  task automatic wait_reset();
    int waited = 0;
    while (!rst_n) begin
      @(negedge clk);
      waited++;
      if (waited > RESET_TIMEOUT) fail_run("reset was never released");
    end
  endtask

  // hold the beat until a rising edge with s_ready takes it
  task automatic send_beat(input stream_beat_t b);
    int waited = 0;
    s_beat  = b;
    s_valid = 1'b1;
    while (!s_ready) begin
      @(negedge clk);
      waited++;
      if (waited > BEAT_TIMEOUT) fail_run("input beat was not accepted in time");
    end
    @(negedge clk);
    sent++;
  endtask

  task automatic wait_output_idle();
    int waited = 0;
    while (m_valid) begin
      @(negedge clk);
      waited++;
      if (waited > IDLE_TIMEOUT) fail_run("output burst did not drain in time");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b0;
    bp_mode = 1'b0;
    seed    = 32'hb561;
    sent    = 0;
    $readmemh("sim/peak_tests.txt", tests_mem);
    wait_reset();
    n_tests = tests_mem[0];
    ptr     = 1;
    for (int t = 0; t < n_tests; t++) begin
      // header: segments, peak index in the test, back-pressure
      n_seg   = tests_mem[ptr];
      peak    = tests_mem[ptr+1];
      bp_mode = tests_mem[ptr+2][0];
      ptr     = ptr + 3;
      chk.begin_test((peak < 0) ? -1 : sent + peak);
      for (int s = 0; s < n_seg; s++) begin
        rep = tests_mem[ptr];
        for (int c = 0; c < NUM_CHANNELS; c++) begin
          beat.chan[c] = tests_mem[ptr+1+c];
        end
        beat.last = 1'b0;
        ptr = ptr + 1 + NUM_CHANNELS;
        repeat (rep) send_beat(beat);
      end
      wait_output_idle();
      chk.close_test();
    end
    s_valid = 1'b0;
    chk.report_counts(sent);
    if (chk.errors + dut.u_det.u_assert.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/peak_tests.txt
// header: segment count, peak beat index within the test (ffffffff = no burst), back-pressure
// segment: repeat count, then ch0 ch1 ch2 ch3 words, re in upper 16 bits, im in lower 16
7
// quiet stream, spike of 256 on ch0
3 10 0
10 00100008 fff00008 0008fff0 fff0fff8
1  01000000 fff00008 0008fff0 fff0fff8
9  00100008 fff00008 0008fff0 fff0fff8
// ch1 magnitude 80 + 49/2 = 104, threshold (25 + 1) * 4 = 104, no burst
3 ffffffff 0
10 00100008 fff00008 0008fff0 fff0fff8
1  00100008 0050ffcf 0008fff0 fff0fff8
9  00100008 fff00008 0008fff0 fff0fff8
// ch1 magnitude 105, one above the threshold
3 10 0
10 00100008 fff00008 0008fff0 fff0fff8
1  00100008 0051ffcf 0008fff0 fff0fff8
9  00100008 fff00008 0008fff0 fff0fff8
// ch2 with negative re, 256 + 32/2 = 272
3 10 0
10 00100008 fff00008 0008fff0 fff0fff8
1  00100008 fff00008 ff000020 fff0fff8
9  00100008 fff00008 0008fff0 fff0fff8
// ch3 with negative im, 80 + 64/2 = 112, random back-pressure
3 10 1
10 00100008 fff00008 0008fff0 fff0fff8
1  00100008 fff00008 0008fff0 0040ffb0
9  00100008 fff00008 0008fff0 fff0fff8
// second spike four beats later falls in the holdoff
5 10 0
10 00100008 fff00008 0008fff0 fff0fff8
1  01000000 fff00008 0008fff0 fff0fff8
3  00100008 fff00008 0008fff0 fff0fff8
1  01000000 fff00008 0008fff0 fff0fff8
b  00100008 fff00008 0008fff0 fff0fff8
// later spike on ch0 im, second burst under back-pressure
3 10 1
10 00100008 fff00008 0008fff0 fff0fff8
1  00000200 fff00008 0008fff0 fff0fff8
9  00100008 fff00008 0008fff0 fff0fff8

//--- sim/tb_clock.sv
////////////////////////////////////////////////////////////
// 8 ns clock, reset low for 5 cycles, released on a falling edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/peak_stream_pkg.sv
design/peak_ctrl_pkg.sv
design/delay_line.sv
design/cabs_approx.sv
design/boxcar_avg.sv
design/peak_detector.sv
design/peak_detect_top.sv
sim/tb_clock.sv
sim/peak_detect_assertions.sv
sim/peak_detect_checker.sv
sim/peak_detect_tb.sv
